//--- hdl/eth_rx_pkg.sv
package eth_rx_pkg;

   // Station address, first byte on the wire in the top bits
   localparam logic [47:0] STATION_MAC = 48'h02_00_5E_10_20_30;
   localparam logic [47:0] BCAST_MAC   = 48'hFF_FF_FF_FF_FF_FF;

   // Receive buffer geometry
   localparam int BUF_BYTE_ADDR_W = 11;                   // 2048 bytes
   localparam int BUF_WORD_ADDR_W = BUF_BYTE_ADDR_W - 2;  // 512 words of 32 bits
   localparam int MAX_FRAME_BYTES = 2 ** BUF_BYTE_ADDR_W;

   // CRC-32 in the reflected form used by Ethernet
   localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
   localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

   // Register value after a good frame and its FCS, no final inversion
   localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

   // One byte from the nibble assembler
   typedef struct packed {
      logic       valid;  // One-cycle pulse per byte
      logic       sof;    // First byte after the delimiter
      logic       eof;    // End of data valid, never with valid
      logic [7:0] data;
   } rx_byte_t;

   // Byte write into the receive buffer
   typedef struct packed {
      logic                       en;
      logic [BUF_BYTE_ADDR_W-1:0] addr;
      logic [7:0]                 data;
   } buf_wr_t;

   // Status seen by the host
   typedef struct packed {
      logic                     data_rcvd;
      logic                     crc_ok;
      logic [BUF_BYTE_ADDR_W:0] size;  // Extra bit so a full buffer fits
      logic                     phy_clk_detected;
      logic                     phy_dv_detected;
   } rx_status_t;

endpackage

//--- hdl/eth_rx_nibble_asm.sv
`timescale 1ns/10ps

module eth_rx_nibble_asm (
   input  logic                 MRxClk,
   input  logic                 ETH_PHY_RESETN,
   input  logic [3:0]           mrxd_i,
   input  logic                 mrxdv_i,
   output eth_rx_pkg::rx_byte_t byte_o
);

   typedef enum logic [1:0] {
      HUNT,
      PREAMBLE,
      DATA,
      WAIT_IDLE
   } asm_state_t;

   asm_state_t state_q;
   logic [3:0] low_nib_q;
   logic       high_next_q;  // Next nibble completes a byte
   logic       first_q;      // Next byte opens the frame

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state_q     <= HUNT;
         low_nib_q   <= 4'h0;
         high_next_q <= 1'b0;
         first_q     <= 1'b0;
         byte_o      <= '0;
      end else begin
         byte_o.valid <= 1'b0;
         byte_o.sof   <= 1'b0;
         byte_o.eof   <= 1'b0;
         case (state_q)
            HUNT: begin
               if (mrxdv_i) begin
                  state_q <= (mrxd_i == 4'h5) ? PREAMBLE : WAIT_IDLE;
               end
            end
            PREAMBLE: begin
               if (!mrxdv_i) begin
                  state_q <= HUNT;
               end else if (mrxd_i == 4'hD) begin  // Delimiter after preamble
                  state_q     <= DATA;
                  high_next_q <= 1'b0;
                  first_q     <= 1'b1;
               end else if (mrxd_i != 4'h5) begin
                  state_q <= WAIT_IDLE;  // Garbage, sit out this burst
               end
            end
            DATA: begin
               if (!mrxdv_i) begin
                  // A half byte left in low_nib_q is simply lost
                  byte_o.eof <= 1'b1;
                  state_q    <= HUNT;
               end else if (high_next_q) begin
                  byte_o.valid <= 1'b1;
                  byte_o.sof   <= first_q;
                  byte_o.data  <= {mrxd_i, low_nib_q};
                  first_q      <= 1'b0;
                  high_next_q  <= 1'b0;
               end else begin
                  low_nib_q   <= mrxd_i;  // Low nibble comes first
                  high_next_q <= 1'b1;
               end
            end
            default: begin
               if (!mrxdv_i) state_q <= HUNT;
            end
         endcase
      end
   end

   // Bytes need two nibbles, so two back-to-back strobes mean a broken pairing
   a_valid_spacing: assert property (
      @(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      byte_o.valid |=> !byte_o.valid
   );

endmodule

//--- hdl/eth_rx_crc32.sv
`timescale 1ns/10ps

module eth_rx_crc32 (
   input  logic                 MRxClk,
   input  logic                 ETH_PHY_RESETN,
   input  eth_rx_pkg::rx_byte_t byte_i,
   output logic                 crc_ok_o
);

   logic [31:0] crc_q;
   logic [31:0] crc_seed;

   // One byte through the reflected LFSR, LSB first as on the wire
   function automatic logic [31:0] crc_byte(input logic [31:0] crc_in,
                                            input logic [7:0]  data);
      logic [31:0] crc;
      crc = crc_in;
      for (int i = 0; i < 8; i++) begin
         if (crc[0] ^ data[i]) begin
            crc = (crc >> 1) ^ eth_rx_pkg::CRC_POLY;
         end else begin
            crc = crc >> 1;
         end
      end
      return crc;
   endfunction

   // First byte of a frame folds into a fresh preset
   assign crc_seed = byte_i.sof ? eth_rx_pkg::CRC_INIT : crc_q;

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         crc_q <= eth_rx_pkg::CRC_INIT;
      end else if (byte_i.valid) begin
         crc_q <= crc_byte(crc_seed, byte_i.data);
      end
   end

   // FCS included, so a clean frame lands on the fixed residue
   assign crc_ok_o = (crc_q == eth_rx_pkg::CRC_RESIDUE);

endmodule

//--- hdl/eth_rx_frame_ctrl.sv
`timescale 1ns/10ps

module eth_rx_frame_ctrl (
   input  logic                                  MRxClk,
   input  logic                                  ETH_PHY_RESETN,
   input  eth_rx_pkg::rx_byte_t                  byte_i,
   input  logic                                  crc_ok_i,
   input  logic                                  rcv_ack_i,
   output eth_rx_pkg::buf_wr_t                   wr_o,
   output logic                                  data_rcvd_o,
   output logic                                  crc_ok_o,
   output logic [eth_rx_pkg::BUF_BYTE_ADDR_W:0] size_o
);

   typedef enum logic [2:0] {
      IDLE,
      MATCHING,
      STORING,
      DROPPING,
      RECEIVED
   } frame_state_t;

   frame_state_t state_q;

   logic [eth_rx_pkg::BUF_BYTE_ADDR_W:0] cnt_q;    // Bytes stored so far
   logic [eth_rx_pkg::BUF_BYTE_ADDR_W:0] wr_addr;  // Position of the incoming byte
   logic                                 ucast_q;
   logic                                 bcast_q;
   logic [47:0]                          ucast_shift;
   logic [47:0]                          bcast_shift;
   logic                                 ucast_hit;
   logic                                 bcast_hit;
   logic                                 at_limit;
   logic                                 store_byte;

   // A new frame always starts at byte 0
   assign wr_addr = (state_q == IDLE) ? '0 : cnt_q;

   // Line up the address byte for this position in the top bits
   assign ucast_shift = eth_rx_pkg::STATION_MAC << (8 * wr_addr[2:0]);
   assign bcast_shift = eth_rx_pkg::BCAST_MAC << (8 * wr_addr[2:0]);

   // Running match, restarted on the first byte
   assign ucast_hit = ((state_q == IDLE) || ucast_q) && (byte_i.data == ucast_shift[47:40]);
   assign bcast_hit = ((state_q == IDLE) || bcast_q) && (byte_i.data == bcast_shift[47:40]);

   assign at_limit = (cnt_q == eth_rx_pkg::MAX_FRAME_BYTES);

   assign store_byte = byte_i.valid &&
                       (((state_q == IDLE) && byte_i.sof) ||
                        (state_q == MATCHING) ||
                        ((state_q == STORING) && !at_limit));

   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         state_q  <= IDLE;
         cnt_q    <= '0;
         ucast_q  <= 1'b0;
         bcast_q  <= 1'b0;
         wr_o     <= '0;
         size_o   <= '0;
         crc_ok_o <= 1'b0;
      end else begin
         wr_o.en <= store_byte;
         if (store_byte) begin
            wr_o.addr <= wr_addr[eth_rx_pkg::BUF_BYTE_ADDR_W-1:0];
            wr_o.data <= byte_i.data;
            cnt_q     <= wr_addr + 1'b1;
         end
         case (state_q)
            IDLE: begin
               if (byte_i.valid && byte_i.sof) begin
                  ucast_q <= ucast_hit;
                  bcast_q <= bcast_hit;
                  state_q <= MATCHING;
               end
            end
            MATCHING: begin
               if (byte_i.eof) begin
                  state_q <= IDLE;  // Runt, shorter than an address
               end else if (byte_i.valid) begin
                  ucast_q <= ucast_hit;
                  bcast_q <= bcast_hit;
                  if (wr_addr == 5) begin
                     state_q <= (ucast_hit || bcast_hit) ? STORING : DROPPING;
                  end
               end
            end
            STORING: begin
               if (byte_i.eof) begin
                  size_o   <= cnt_q;
                  crc_ok_o <= crc_ok_i;
                  state_q  <= RECEIVED;
               end else if (byte_i.valid && at_limit) begin
                  state_q <= DROPPING;  // Too long, throw it all away
               end
            end
            DROPPING: begin
               if (byte_i.eof) state_q <= IDLE;
            end
            default: begin
               // Held until the host is done, new frames pass by
               if (rcv_ack_i) state_q <= IDLE;
            end
         endcase
      end
   end

   assign data_rcvd_o = (state_q == RECEIVED);

   // Buffer content must stay frozen while the host owns it
   a_no_write_when_held: assert property (
      @(posedge MRxClk) disable iff (!ETH_PHY_RESETN)
      data_rcvd_o |-> !wr_o.en
   );

endmodule

//--- hdl/eth_rx_buffer.sv
`timescale 1ns/10ps

module eth_rx_buffer (
   input  logic                                   MRxClk,
   input  eth_rx_pkg::buf_wr_t                    wr_i,
   input  logic                                   rd_en_i,
   input  logic [eth_rx_pkg::BUF_WORD_ADDR_W-1:0] rd_addr_i,
   output logic [31:0]                            rd_data_o
);

   logic [31:0] mem [0:2**eth_rx_pkg::BUF_WORD_ADDR_W-1];

   logic [eth_rx_pkg::BUF_WORD_ADDR_W-1:0] wr_word;
   logic [1:0]                             wr_lane;
   logic [3:0]                             wr_strb;
   logic [31:0]                            wr_data;

   // Byte address splits into word and lane, lane 0 in the low bits
   assign wr_word = wr_i.addr[eth_rx_pkg::BUF_BYTE_ADDR_W-1:2];
   assign wr_lane = wr_i.addr[1:0];

   // Enable and byte both shifted up to their lane
   assign wr_strb = {3'b000, wr_i.en} << wr_lane;
   assign wr_data = {24'h00_0000, wr_i.data} << (8 * wr_lane);

   always_ff @(posedge MRxClk) begin
      for (int i = 0; i < 4; i++) begin
         if (wr_strb[i]) begin
            mem[wr_word][8*i +: 8] <= wr_data[8*i +: 8];  // Other lanes untouched
         end
      end
   end

   // Host side, holds the last word read
   always_ff @(posedge MRxClk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

   // A single byte per write, never a partial word of several lanes
   a_strb_onehot: assert property (
      @(posedge MRxClk)
      wr_i.en |-> $onehot(wr_strb)
   );

endmodule

//--- hdl/eth_rx_core.sv
`timescale 1ns/10ps

module eth_rx_core (
   input  logic                                   MRxClk,
   input  logic                                   ETH_PHY_RESETN,
   input  logic [3:0]                             mrxd_i,
   input  logic                                   mrxdv_i,
   input  logic                                   rcv_ack_i,
   input  logic                                   rd_en_i,
   input  logic [eth_rx_pkg::BUF_WORD_ADDR_W-1:0] rd_addr_i,
   output logic [31:0]                            rd_data_o,
   output eth_rx_pkg::rx_status_t                 rx_status_o
);

   eth_rx_pkg::rx_byte_t rx_byte;
   eth_rx_pkg::buf_wr_t  buf_wr;

   logic                                 crc_ok;          // Live compare
   logic                                 crc_ok_latched;  // Frozen at frame end
   logic                                 data_rcvd;
   logic [eth_rx_pkg::BUF_BYTE_ADDR_W:0] size;
   logic                                 phy_clk_detected;
   logic                                 phy_dv_detected;

   // Sticky link activity flags
   always_ff @(posedge MRxClk or negedge ETH_PHY_RESETN) begin
      if (!ETH_PHY_RESETN) begin
         phy_clk_detected <= 1'b0;
         phy_dv_detected  <= 1'b0;
      end else begin
         phy_clk_detected <= 1'b1;  // Any edge proves the clock runs
         if (mrxdv_i) phy_dv_detected <= 1'b1;
      end
   end

   eth_rx_nibble_asm u_nibble_asm (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .mrxd_i        (mrxd_i),
      .mrxdv_i       (mrxdv_i),
      .byte_o        (rx_byte)
   );

   eth_rx_crc32 u_crc32 (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .byte_i        (rx_byte),
      .crc_ok_o      (crc_ok)
   );

   eth_rx_frame_ctrl u_frame_ctrl (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .byte_i        (rx_byte),
      .crc_ok_i      (crc_ok),
      .rcv_ack_i     (rcv_ack_i),
      .wr_o          (buf_wr),
      .data_rcvd_o   (data_rcvd),
      .crc_ok_o      (crc_ok_latched),
      .size_o        (size)
   );

   eth_rx_buffer u_buffer (
      .MRxClk   (MRxClk),
      .wr_i     (buf_wr),
      .rd_en_i  (rd_en_i),
      .rd_addr_i(rd_addr_i),
      .rd_data_o(rd_data_o)
   );

   assign rx_status_o = '{
      data_rcvd:        data_rcvd,
      crc_ok:           crc_ok_latched,
      size:             size,
      phy_clk_detected: phy_clk_detected,
      phy_dv_detected:  phy_dv_detected
   };

endmodule

//--- verification/eth_rx_tb_frames.svh
// Reflected CRC-32, one byte folded in at a time
function automatic logic [31:0] crc_step(input logic [31:0] crc_in, input logic [7:0] b);
   logic [31:0] c;
   c = crc_in ^ {24'h00_0000, b};
   for (int k = 0; k < 8; k++) begin
      c = c[0] ? ((c >> 1) ^ TB_CRC_POLY) : (c >> 1);
   end
   return c;
endfunction

// Append FCS over all bytes before it, low byte first on the wire
task automatic add_fcs();
   logic [31:0] crc;
   crc = 32'hFFFF_FFFF;
   for (int i = 0; i < frame_len - 4; i++) begin
      crc = crc_step(crc, frame[i]);
   end
   crc = ~crc;
   for (int b = 0; b < 4; b++) begin
      frame[frame_len - 4 + b] = crc[8*b +: 8];
   end
endtask

// Good frame means the running CRC over data and FCS lands on the residue
function automatic logic fcs_matches();
   logic [31:0] crc;
   crc = 32'hFFFF_FFFF;
   for (int i = 0; i < frame_len; i++) begin
      crc = crc_step(crc, frame[i]);
   end
   return (crc == TB_RESIDUE);
endfunction

// Header, counting payload, then FCS
task automatic build_frame(input logic [47:0] dest, input int len, input logic [7:0] seed);
   logic [47:0] src;
   src       = 48'h02_AA_BB_CC_DD_EE;
   frame_len = len;
   for (int i = 0; i < 6; i++) begin
      frame[i]     = dest[47-8*i -: 8];  // First byte on the wire from the top
      frame[6 + i] = src[47-8*i -: 8];
   end
   frame[12] = 8'h08;
   frame[13] = 8'h00;
   for (int i = 14; i < len - 4; i++) begin
      frame[i] = seed + 8'(i);
   end
   add_fcs();
endtask

task automatic drive_nibble(input logic [3:0] nib);
   @(negedge MRxClk);
   mrxdv_i = 1'b1;
   mrxd_i  = nib;
endtask

// Preamble, delimiter, then each byte low nibble first
task automatic send_frame();
   for (int i = 0; i < 15; i++) begin
      drive_nibble(4'h5);
   end
   drive_nibble(4'hD);
   for (int i = 0; i < frame_len; i++) begin
      drive_nibble(frame[i][3:0]);
      drive_nibble(frame[i][7:4]);
   end
   @(negedge MRxClk);
   mrxdv_i = 1'b0;
   mrxd_i  = 4'h0;
   repeat (6) @(negedge MRxClk);  // Interframe gap
endtask

// One cycle read latency on the host port
task automatic read_word(input logic [8:0] addr, output logic [31:0] data);
   @(negedge MRxClk);
   rd_en_i   = 1'b1;
   rd_addr_i = addr;
   @(negedge MRxClk);
   rd_en_i = 1'b0;
   data    = rd_data_o;
endtask

// Byte k in word k/4, lane k mod 4, lanes past the end ignored
task automatic check_buffer(input string test);
   logic [31:0] got;
   logic [31:0] exp;
   logic [31:0] mask;
   int          nwords;
   nwords = (frame_len + 3) / 4;
   for (int w = 0; w < nwords; w++) begin
      exp  = '0;
      mask = '0;
      for (int l = 0; l < 4; l++) begin
         if (4*w + l < frame_len) begin
            exp[8*l +: 8]  = frame[4*w + l];
            mask[8*l +: 8] = 8'hFF;
         end
      end
      read_word(9'(w), got);
      compare_value(test, $sformatf("buffer word %0d", w), exp, got & mask);
   end
endtask

task automatic check_received(input string test);
   wait_rcvd(test, 1'b1, "the received flag");
   compare_value(test, "size", 32'(frame_len), 32'(rx_status_o.size));
   compare_value(test, "crc_ok", 32'(fcs_matches()), 32'(rx_status_o.crc_ok));
   check_buffer(test);
endtask

task automatic ack_frame(input string test);
   @(negedge MRxClk);
   rcv_ack_i = 1'b1;
   @(negedge MRxClk);
   rcv_ack_i = 1'b0;
   wait_rcvd(test, 1'b0, "the received flag to clear");
endtask

//--- verification/eth_rx_tb.sv
`timescale 1ns/10ps

module eth_rx_tb;

   localparam logic [31:0] RAND_SEED    = 32'hfff5a07f;
   localparam logic [31:0] TB_CRC_POLY  = 32'hEDB8_8320;
   localparam logic [31:0] TB_RESIDUE   = 32'hDEBB_20E3;
   localparam logic [47:0] OTHER_MAC    = 48'h02_00_5E_10_20_31;
   localparam int          RCVD_TIMEOUT = 40;   // Cycles after the gap
   localparam int          QUIET_WINDOW = 200;

   logic                   MRxClk;
   logic                   ETH_PHY_RESETN;
   logic [3:0]             mrxd_i;
   logic                   mrxdv_i;
   logic                   rcv_ack_i;
   logic                   rd_en_i;
   logic [8:0]             rd_addr_i;
   logic [31:0]            rd_data_o;
   eth_rx_pkg::rx_status_t rx_status_o;

   logic [7:0] frame [0:2047];  // Current frame with its FCS
   int         frame_len;
   int         checks;
   int         errors;
   int         timeouts;

   function automatic void compare_value(input string test, input string what,
                                         input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[ERROR] %s %s: expected %0h, actual %0h", test, what, exp, act);
      end
   endfunction

   task automatic wait_rcvd(input string test, input logic level, input string what);
      int n;
      n = 0;
      while (rx_status_o.data_rcvd !== level && n < RCVD_TIMEOUT) begin
         @(negedge MRxClk);
         n++;
      end
      if (rx_status_o.data_rcvd !== level) begin
         timeouts++;
         $display("[ERROR] %s: timed out waiting for %s", test, what);
      end
   endtask

   // Flag must keep its level through the whole window
   task automatic hold_check(input string test, input logic level);
      int bad;
      bad = 0;
      for (int n = 0; n < QUIET_WINDOW; n++) begin
         @(negedge MRxClk);
         if (rx_status_o.data_rcvd !== level) bad++;
      end
      compare_value(test, "cycles with a wrong received flag", 0, 32'(bad));
   endtask

   `include "eth_rx_tb_frames.svh"

   eth_rx_core DUT (
      .MRxClk        (MRxClk),
      .ETH_PHY_RESETN(ETH_PHY_RESETN),
      .mrxd_i        (mrxd_i),
      .mrxdv_i       (mrxdv_i),
      .rcv_ack_i     (rcv_ack_i),
      .rd_en_i       (rd_en_i),
      .rd_addr_i     (rd_addr_i),
      .rd_data_o     (rd_data_o),
      .rx_status_o   (rx_status_o)
   );

   initial begin
      MRxClk = 1'b0;
      forever #20 MRxClk = ~MRxClk;
   end

   task automatic reset_state();
      int n;
      compare_value("reset_state", "data_rcvd", 0, 32'(rx_status_o.data_rcvd));
      compare_value("reset_state", "crc_ok", 0, 32'(rx_status_o.crc_ok));
      compare_value("reset_state", "size", 0, 32'(rx_status_o.size));
      compare_value("reset_state", "phy_dv_detected", 0, 32'(rx_status_o.phy_dv_detected));
      n = 0;
      while (rx_status_o.phy_clk_detected !== 1'b1 && n < 4) begin
         @(negedge MRxClk);
         n++;
      end
      if (rx_status_o.phy_clk_detected !== 1'b1) begin
         timeouts++;
         $display("[ERROR] reset_state: PHY clock flag never came up");
      end
   endtask

   task automatic unicast_good();
      build_frame(eth_rx_pkg::STATION_MAC, 64, 8'h10);
      send_frame();
      check_received("unicast_good");
      ack_frame("unicast_good");
      compare_value("unicast_good", "phy_dv_detected", 1, 32'(rx_status_o.phy_dv_detected));
   endtask

   task automatic filter();
      build_frame(eth_rx_pkg::BCAST_MAC, 90, 8'h33);
      send_frame();
      check_received("filter");
      ack_frame("filter");
      build_frame(OTHER_MAC, 90, 8'h77);  // One bit off the station address
      send_frame();
      hold_check("filter", 1'b0);
   endtask

   task automatic bad_fcs();
      build_frame(eth_rx_pkg::STATION_MAC, 100, 8'h21);
      frame[30] = frame[30] ^ 8'h10;
      send_frame();
      check_received("bad_fcs");
      ack_frame("bad_fcs");
   endtask

   task automatic held_frame();
      build_frame(eth_rx_pkg::STATION_MAC, 80, 8'h40);
      send_frame();
      check_received("held_frame");
      build_frame(eth_rx_pkg::STATION_MAC, 120, 8'h90);
      send_frame();
      hold_check("held_frame", 1'b1);
      compare_value("held_frame", "size", 80, 32'(rx_status_o.size));
      build_frame(eth_rx_pkg::STATION_MAC, 80, 8'h40);  // First frame again as reference
      check_buffer("held_frame");
      ack_frame("held_frame");
      build_frame(eth_rx_pkg::STATION_MAC, 72, 8'h05);
      send_frame();
      check_received("held_frame");
      ack_frame("held_frame");
   endtask

   task automatic random_frames();
      int len;
      for (int f = 0; f < 5; f++) begin
         len = $urandom_range(300, 60);
         build_frame(eth_rx_pkg::STATION_MAC, len, 8'h00);
         for (int i = 14; i < len - 4; i++) begin
            frame[i] = 8'($urandom);
         end
         add_fcs();
         send_frame();
         check_received("random_frames");
         ack_frame("random_frames");
      end
   endtask

   initial begin
      void'($urandom(RAND_SEED));
      checks         = 0;
      errors         = 0;
      timeouts       = 0;
      ETH_PHY_RESETN = 1'b0;
      mrxd_i         = 4'h0;
      mrxdv_i        = 1'b0;
      rcv_ack_i      = 1'b0;
      rd_en_i        = 1'b0;
      rd_addr_i      = '0;
      repeat (2) @(negedge MRxClk);
      ETH_PHY_RESETN = 1'b1;

      reset_state();
      unicast_good();
      filter();
      bad_fcs();
      held_frame();
      random_frames();

      $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- eth_rx_core.f
+incdir+verification
hdl/eth_rx_pkg.sv
hdl/eth_rx_nibble_asm.sv
hdl/eth_rx_crc32.sv
hdl/eth_rx_frame_ctrl.sv
hdl/eth_rx_buffer.sv
hdl/eth_rx_core.sv
verification/eth_rx_tb.sv

//--- build.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module eth_rx_tb \
   -f eth_rx_core.f \
   -o eth_rx_sim

sim_out=$(./obj_dir/eth_rx_sim)
echo "$sim_out"

if grep -qx "Done: no errors" <<< "$sim_out"; then
   exit 0
fi
exit 1
